// ==== design/dma_defines.svh ====
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_NUM_STREAMS      2   // at most 4, one LISR byte each
`define DMA_DATA_W           32

// word offsets
`define DMA_ADDR_LISR        0
`define DMA_ADDR_LIFCR       1
`define DMA_ADDR_S0_CR       2
`define DMA_REGS_PER_STREAM  4   // CR, NDTR, PAR, MAR

// flag bits inside a stream's byte of LISR and LIFCR
`define DMA_ISR_TC_BIT       0
`define DMA_ISR_HT_BIT       2
`define DMA_ISR_TE_BIT       3

// CR fields
`define DMA_CR_EN_BIT        0
`define DMA_CR_TEIE_BIT      2
`define DMA_CR_HTIE_BIT      3
`define DMA_CR_TCIE_BIT      4
`define DMA_CR_DIR_LSB       6   // 7:6
`define DMA_CR_CIRC_BIT      8
`define DMA_CR_PINC_BIT      9
`define DMA_CR_MINC_BIT      10
`define DMA_CR_PSIZE_LSB     11  // 12:11
`define DMA_CR_MSIZE_LSB     13  // 14:13

`endif

// ==== design/dma_pkg.sv ====
`default_nettype none
`include "dma_defines.svh"

package dma_pkg;

    typedef enum logic [1:0] {
        periph_to_mem,
        mem_to_periph,
        mem_to_mem
    } dma_dir_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } dma_size_e;

    // what a bus address points at
    typedef enum logic [2:0] {
        reg_lisr,
        reg_lifcr,
        reg_cr,
        reg_ndtr,
        reg_par,
        reg_mar,
        reg_none
    } dma_reg_kind_e;

    typedef struct packed {
        dma_dir_e  dir;
        dma_size_e msize;
        dma_size_e psize;
        logic      minc;
        logic      pinc;
        logic      circ;
        logic      tcie;
        logic      htie;
        logic      teie;
        logic      en;
    } dma_stream_cfg_t;

    // one bus write, already steered to a single stream
    typedef struct packed {
        logic                      cr_we;
        logic                      ndtr_we;
        logic                      par_we;
        logic                      mar_we;
        logic [`DMA_DATA_W/8-1:0]  strb;
        logic [`DMA_DATA_W-1:0]    data;
    } dma_wr_t;

    typedef struct packed {
        logic tc_set;
        logic ht_set;
    } dma_evt_t;

endpackage

`default_nettype wire

// ==== design/dma_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_bus_decode import dma_pkg::*; #(
    parameter int STREAM_W = 1
) (
    input  logic [`DMA_DATA_W-1:0] i_addr,
    output dma_reg_kind_e          o_kind,
    output logic [STREAM_W-1:0]    o_stream
);

localparam int NUM    = `DMA_NUM_STREAMS;
localparam int STRIDE = `DMA_REGS_PER_STREAM;
localparam int AW     = `DMA_DATA_W - 2;

logic [AW-1:0] word_addr;
logic [AW-1:0] offs;      // words past the first stream block
logic [AW-1:0] reg_idx;

assign word_addr = i_addr[`DMA_DATA_W-1:2];   // byte offset ignored
assign offs      = word_addr - AW'(`DMA_ADDR_S0_CR);
assign reg_idx   = offs % AW'(STRIDE);

always_comb begin
    o_kind   = reg_none;
    o_stream = '0;
    if (word_addr == AW'(`DMA_ADDR_LISR)) begin
        o_kind = reg_lisr;
    end else if (word_addr == AW'(`DMA_ADDR_LIFCR)) begin
        o_kind = reg_lifcr;
    end else if (word_addr >= AW'(`DMA_ADDR_S0_CR) && offs < AW'(NUM * STRIDE)) begin
        o_stream = STREAM_W'(offs / AW'(STRIDE));
        case (reg_idx)
            AW'(0): o_kind = reg_cr;
            AW'(1): o_kind = reg_ndtr;
            AW'(2): o_kind = reg_par;
            AW'(3): o_kind = reg_mar;
            default: o_kind = reg_none;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== design/dma_stream_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_stream_regs import dma_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_nreset,
    input  dma_wr_t                i_wr,
    input  logic                   i_ndtr_decr,
    output dma_stream_cfg_t        o_cfg,
    output logic [15:0]            o_ndtr,
    output logic [`DMA_DATA_W-1:0] o_par,
    output logic [`DMA_DATA_W-1:0] o_mar,
    output dma_evt_t               o_evt
);

localparam int NBYTES = `DMA_DATA_W / 8;

logic        cr_byte0_we;  // EN, interrupt enables and DIR
logic        cr_byte1_we;  // the rest, locked while enabled
logic        en_load;      // disabled stream gets EN=1
logic        ndtr_zero;
logic        circ_load;
logic        ndtr_we;
logic [15:0] ndtr_shadow;

function automatic logic [`DMA_DATA_W-1:0] merge_bytes(
    input logic [`DMA_DATA_W-1:0] old_val,
    input logic [`DMA_DATA_W-1:0] new_val,
    input logic [NBYTES-1:0]      strb
);
    logic [`DMA_DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < NBYTES; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
        end
    end
    return res;
endfunction

assign cr_byte0_we = i_wr.cr_we & i_wr.strb[0];
assign cr_byte1_we = i_wr.cr_we & i_wr.strb[1] & ~o_cfg.en;
assign en_load     = cr_byte0_we & i_wr.data[`DMA_CR_EN_BIT] & ~o_cfg.en;
assign ndtr_zero   = (o_ndtr == 16'd0);
assign circ_load   = o_cfg.en & o_cfg.circ & ndtr_zero;
assign ndtr_we     = i_wr.ndtr_we & ~o_cfg.en;

always_ff @(posedge i_clk or negedge i_nreset) begin
    if (!i_nreset) begin
        o_cfg <= '0;
    end else begin
        if (cr_byte0_we) begin
            o_cfg.tcie <= i_wr.data[`DMA_CR_TCIE_BIT];
            o_cfg.htie <= i_wr.data[`DMA_CR_HTIE_BIT];
            o_cfg.teie <= i_wr.data[`DMA_CR_TEIE_BIT];
            if (!o_cfg.en) begin
                o_cfg.dir <= dma_dir_e'(i_wr.data[`DMA_CR_DIR_LSB +: 2]);
            end
        end
        if (cr_byte1_we) begin
            o_cfg.circ  <= i_wr.data[`DMA_CR_CIRC_BIT];
            o_cfg.pinc  <= i_wr.data[`DMA_CR_PINC_BIT];
            o_cfg.minc  <= i_wr.data[`DMA_CR_MINC_BIT];
            o_cfg.psize <= dma_size_e'(i_wr.data[`DMA_CR_PSIZE_LSB +: 2]);
            o_cfg.msize <= dma_size_e'(i_wr.data[`DMA_CR_MSIZE_LSB +: 2]);
        end
        // a write disables at once, completion only in normal mode
        if (cr_byte0_we) begin
            o_cfg.en <= i_wr.data[`DMA_CR_EN_BIT];
        end else if (o_cfg.en && !o_cfg.circ && ndtr_zero) begin
            o_cfg.en <= 1'b0;
        end
    end
end

// counter and shadow take the same bus write
always_ff @(posedge i_clk or negedge i_nreset) begin
    if (!i_nreset) begin
        o_ndtr      <= '0;
        ndtr_shadow <= '0;
    end else if (ndtr_we) begin
        for (int b = 0; b < 2; b++) begin
            if (i_wr.strb[b]) begin
                o_ndtr[8*b +: 8]      <= i_wr.data[8*b +: 8];
                ndtr_shadow[8*b +: 8] <= i_wr.data[8*b +: 8];
            end
        end
    end else if (en_load || circ_load) begin
        o_ndtr <= ndtr_shadow;
    end else if (o_cfg.en && i_ndtr_decr && !ndtr_zero) begin
        o_ndtr <= o_ndtr - 16'd1;
    end
end

always_ff @(posedge i_clk or negedge i_nreset) begin
    if (!i_nreset) begin
        o_par <= '0;
        o_mar <= '0;
    end else if (!o_cfg.en) begin
        if (i_wr.par_we) begin
            o_par <= merge_bytes(o_par, i_wr.data, i_wr.strb);
        end
        if (i_wr.mar_we) begin
            o_mar <= merge_bytes(o_mar, i_wr.data, i_wr.strb);
        end
    end
end

assign o_evt = '{
    tc_set: o_cfg.en & ndtr_zero,
    ht_set: o_cfg.en & (o_ndtr == (ndtr_shadow >> 1))  // halfway through the block
};

endmodule

`default_nettype wire

// ==== design/dma_irq_flags.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_irq_flags import dma_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_nreset,
    input  dma_evt_t                    i_evt [`DMA_NUM_STREAMS-1:0],
    input  logic [`DMA_NUM_STREAMS-1:0] i_teif_set,
    input  logic                        i_clr_we,
    input  logic [`DMA_DATA_W/8-1:0]    i_byte_strobe,
    input  logic [`DMA_DATA_W-1:0]      i_wdata,
    output logic [`DMA_NUM_STREAMS-1:0] o_tcif,
    output logic [`DMA_NUM_STREAMS-1:0] o_htif,
    output logic [`DMA_NUM_STREAMS-1:0] o_teif,
    output logic [`DMA_DATA_W-1:0]      o_lisr
);

localparam int N = `DMA_NUM_STREAMS;

// per stream {te, ht, tc}
logic [2:0] flag_set [N-1:0];
logic [2:0] flag_clr [N-1:0];
logic [2:0] flags    [N-1:0];

always_comb begin
    for (int s = 0; s < N; s++) begin
        flag_set[s] = {i_teif_set[s], i_evt[s].ht_set, i_evt[s].tc_set};
        flag_clr[s] = '0;
        if (i_clr_we && i_byte_strobe[s]) begin  // stream s owns byte s
            flag_clr[s] = {i_wdata[8*s + `DMA_ISR_TE_BIT],
                           i_wdata[8*s + `DMA_ISR_HT_BIT],
                           i_wdata[8*s + `DMA_ISR_TC_BIT]};
        end
    end
end

// set beats a clear in the same cycle
always_ff @(posedge i_clk or negedge i_nreset) begin
    if (!i_nreset) begin
        for (int s = 0; s < N; s++) begin
            flags[s] <= '0;
        end
    end else begin
        for (int s = 0; s < N; s++) begin
            flags[s] <= flag_set[s] | (flags[s] & ~flag_clr[s]);
        end
    end
end

always_comb begin
    o_lisr = '0;
    for (int s = 0; s < N; s++) begin
        o_tcif[s] = flags[s][0];
        o_htif[s] = flags[s][1];
        o_teif[s] = flags[s][2];
        o_lisr[8*s + `DMA_ISR_TC_BIT] = flags[s][0];
        o_lisr[8*s + `DMA_ISR_HT_BIT] = flags[s][1];
        o_lisr[8*s + `DMA_ISR_TE_BIT] = flags[s][2];
    end
end

endmodule

`default_nettype wire

// ==== design/dma_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_regs import dma_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_nreset,
    input  logic [`DMA_DATA_W-1:0]      i_addr,
    input  logic                        i_read_en,
    input  logic                        i_write_en,
    input  logic [`DMA_DATA_W/8-1:0]    i_byte_strobe,
    input  logic [`DMA_DATA_W-1:0]      i_wdata,
    output logic [`DMA_DATA_W-1:0]      o_rdata,
    input  logic [`DMA_NUM_STREAMS-1:0] i_ndtr_decr,
    input  logic [`DMA_NUM_STREAMS-1:0] i_teif_set,
    output dma_stream_cfg_t             o_cfg  [`DMA_NUM_STREAMS-1:0],
    output logic [15:0]                 o_ndtr [`DMA_NUM_STREAMS-1:0],
    output logic [`DMA_DATA_W-1:0]      o_par  [`DMA_NUM_STREAMS-1:0],
    output logic [`DMA_DATA_W-1:0]      o_mar  [`DMA_NUM_STREAMS-1:0],
    output logic [`DMA_NUM_STREAMS-1:0] o_tcif,
    output logic [`DMA_NUM_STREAMS-1:0] o_htif,
    output logic [`DMA_NUM_STREAMS-1:0] o_teif
);

localparam int N        = `DMA_NUM_STREAMS;
localparam int STREAM_W = (N > 1) ? $clog2(N) : 1;

dma_reg_kind_e          kind;
logic [STREAM_W-1:0]    stream;
logic                   lifcr_we;
dma_wr_t                wr      [N-1:0];
dma_evt_t               evt     [N-1:0];
logic [`DMA_DATA_W-1:0] cr_word [N-1:0];
logic [`DMA_DATA_W-1:0] lisr;

dma_bus_decode #(.STREAM_W(STREAM_W)) u_decode (
    .i_addr   (i_addr),
    .o_kind   (kind),
    .o_stream (stream)
);

genvar s;
generate
    for (s = 0; s < N; s++) begin : g_stream
        logic hit;
        assign hit = i_write_en && (stream == STREAM_W'(s));
        assign wr[s] = '{
            cr_we:   hit && (kind == reg_cr),
            ndtr_we: hit && (kind == reg_ndtr),
            par_we:  hit && (kind == reg_par),
            mar_we:  hit && (kind == reg_mar),
            strb:    i_byte_strobe,
            data:    i_wdata
        };

        dma_stream_regs u_stream (
            .i_clk       (i_clk),
            .i_nreset    (i_nreset),
            .i_wr        (wr[s]),
            .i_ndtr_decr (i_ndtr_decr[s]),
            .o_cfg       (o_cfg[s]),
            .o_ndtr      (o_ndtr[s]),
            .o_par       (o_par[s]),
            .o_mar       (o_mar[s]),
            .o_evt       (evt[s])
        );

        // CR as the bus sees it
        always_comb begin
            cr_word[s] = '0;
            cr_word[s][`DMA_CR_EN_BIT]          = o_cfg[s].en;
            cr_word[s][`DMA_CR_TEIE_BIT]        = o_cfg[s].teie;
            cr_word[s][`DMA_CR_HTIE_BIT]        = o_cfg[s].htie;
            cr_word[s][`DMA_CR_TCIE_BIT]        = o_cfg[s].tcie;
            cr_word[s][`DMA_CR_DIR_LSB +: 2]    = o_cfg[s].dir;
            cr_word[s][`DMA_CR_CIRC_BIT]        = o_cfg[s].circ;
            cr_word[s][`DMA_CR_PINC_BIT]        = o_cfg[s].pinc;
            cr_word[s][`DMA_CR_MINC_BIT]        = o_cfg[s].minc;
            cr_word[s][`DMA_CR_PSIZE_LSB +: 2]  = o_cfg[s].psize;
            cr_word[s][`DMA_CR_MSIZE_LSB +: 2]  = o_cfg[s].msize;
        end
    end
endgenerate

assign lifcr_we = i_write_en && (kind == reg_lifcr);

dma_irq_flags u_irq_flags (
    .i_clk         (i_clk),
    .i_nreset      (i_nreset),
    .i_evt         (evt),
    .i_teif_set    (i_teif_set),
    .i_clr_we      (lifcr_we),
    .i_byte_strobe (i_byte_strobe),
    .i_wdata       (i_wdata),
    .o_tcif        (o_tcif),
    .o_htif        (o_htif),
    .o_teif        (o_teif),
    .o_lisr        (lisr)
);

always_comb begin
    o_rdata = '0;
    if (i_read_en) begin
        case (kind)
            reg_lisr:  o_rdata = lisr;
            reg_lifcr: o_rdata = '0;             // write only
            reg_cr:    o_rdata = cr_word[stream];
            reg_ndtr:  o_rdata = {{(`DMA_DATA_W-16){1'b0}}, o_ndtr[stream]};
            reg_par:   o_rdata = o_par[stream];
            reg_mar:   o_rdata = o_mar[stream];
            default:   o_rdata = '0;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== tests/dma_regs_assert.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_regs_assert import dma_pkg::*; (
    input logic                        i_clk,
    input logic                        i_nreset,
    input logic [`DMA_DATA_W-1:0]      i_addr,
    input logic                        i_read_en,
    input logic                        i_write_en,
    input logic [`DMA_DATA_W-1:0]      i_rdata,
    input logic [`DMA_NUM_STREAMS-1:0] i_tcif,
    input logic [15:0]                 i_ndtr [`DMA_NUM_STREAMS-1:0],
    input dma_stream_cfg_t             i_cfg  [`DMA_NUM_STREAMS-1:0]
);

localparam int AW = `DMA_DATA_W - 2;

rdata_idle: assert property (@(posedge i_clk) disable iff (!i_nreset)
    !i_read_en |-> i_rdata == '0)
    else $error("read data is not zero while no read is active");

genvar s;
generate
    for (s = 0; s < `DMA_NUM_STREAMS; s++) begin : g_stream
        localparam logic [AW-1:0] CR_WORD = AW'(`DMA_ADDR_S0_CR + s * `DMA_REGS_PER_STREAM);

        // flag rises one edge after the counter read zero
        tc_needs_zero: assert property (@(posedge i_clk) disable iff (!i_nreset)
            $rose(i_tcif[s]) |-> $past(i_ndtr[s]) == 16'd0)
            else $error("tc flag of stream %0d rose with a nonzero counter", s);

        en_needs_write: assert property (@(posedge i_clk) disable iff (!i_nreset)
            $rose(i_cfg[s].en) |-> $past(i_write_en && i_addr[`DMA_DATA_W-1:2] == CR_WORD))
            else $error("stream %0d enabled without a CR write", s);
    end
endgenerate

endmodule

bind dma_regs dma_regs_assert u_assert (
    .i_clk      (i_clk),
    .i_nreset   (i_nreset),
    .i_addr     (i_addr),
    .i_read_en  (i_read_en),
    .i_write_en (i_write_en),
    .i_rdata    (o_rdata),
    .i_tcif     (o_tcif),
    .i_ndtr     (o_ndtr),
    .i_cfg      (o_cfg)
);

`default_nettype wire

// ==== tests/dma_regs_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dma_defines.svh"

module dma_regs_tb import dma_pkg::*; ();

localparam int N = `DMA_NUM_STREAMS;
localparam int CLK_HALF = 10;
localparam int R_CR = 0;
localparam int R_NDTR = 1;
localparam int R_PAR = 2;
localparam int R_MAR = 3;
localparam logic [31:0] LISR_ADDR = 32'(`DMA_ADDR_LISR * 4);
localparam logic [31:0] LIFCR_ADDR = 32'(`DMA_ADDR_LIFCR * 4);
localparam logic [31:0] CR_MASK = 32'h0000_7fdd;  // implemented CR bits

logic            clk;
logic            nreset;
logic [31:0]     addr;
logic            read_en;
logic            write_en;
logic [3:0]      strobe;
logic [31:0]     wdata;
logic [31:0]     rdata;
logic [N-1:0]    ndtr_decr;
logic [N-1:0]    teif_set;
dma_stream_cfg_t cfg  [N-1:0];
logic [15:0]     ndtr [N-1:0];
logic [31:0]     par  [N-1:0];
logic [31:0]     mar  [N-1:0];
logic [N-1:0]    tcif;
logic [N-1:0]    htif;
logic [N-1:0]    teif;
int              check_errors;
int              timeout_errors;

dma_regs u_dma_regs (
    .i_clk         (clk),
    .i_nreset      (nreset),
    .i_addr        (addr),
    .i_read_en     (read_en),
    .i_write_en    (write_en),
    .i_byte_strobe (strobe),
    .i_wdata       (wdata),
    .o_rdata       (rdata),
    .i_ndtr_decr   (ndtr_decr),
    .i_teif_set    (teif_set),
    .o_cfg         (cfg),
    .o_ndtr        (ndtr),
    .o_par         (par),
    .o_mar         (mar),
    .o_tcif        (tcif),
    .o_htif        (htif),
    .o_teif        (teif)
);

initial clk = 1'b0;
always #(CLK_HALF) clk = ~clk;

function automatic logic [31:0] reg_addr(input int s, input int r);
    return 32'((`DMA_ADDR_S0_CR + s * `DMA_REGS_PER_STREAM + r) * 4);
endfunction

function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (new_val & mask) | (old_val & ~mask);
endfunction

function automatic dma_stream_cfg_t cfg_from_word(input logic [31:0] w);
    dma_stream_cfg_t c;
    c.dir   = dma_dir_e'(w[`DMA_CR_DIR_LSB +: 2]);
    c.msize = dma_size_e'(w[`DMA_CR_MSIZE_LSB +: 2]);
    c.psize = dma_size_e'(w[`DMA_CR_PSIZE_LSB +: 2]);
    c.minc  = w[`DMA_CR_MINC_BIT];
    c.pinc  = w[`DMA_CR_PINC_BIT];
    c.circ  = w[`DMA_CR_CIRC_BIT];
    c.tcie  = w[`DMA_CR_TCIE_BIT];
    c.htie  = w[`DMA_CR_HTIE_BIT];
    c.teie  = w[`DMA_CR_TEIE_BIT];
    c.en    = w[`DMA_CR_EN_BIT];
    return c;
endfunction

task automatic check_equal(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        check_errors++;
        $display("[FAIL] %s: %s expected %h actual %h", test, what, exp, act);
    end
endtask

task automatic bus_write(input logic [31:0] a, input logic [3:0] strb, input logic [31:0] d);
    @(negedge clk);
    addr     = a;
    strobe   = strb;
    wdata    = d;
    write_en = 1'b1;
    @(negedge clk);
    write_en = 1'b0;
    strobe   = 4'h0;
endtask

task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
    @(negedge clk);
    addr    = a;
    read_en = 1'b1;
    #(CLK_HALF / 2);  // mid low phase, data settled
    d = rdata;
    @(negedge clk);
    read_en = 1'b0;
endtask

task automatic check_read(input string test, input string what,
                          input logic [31:0] a, input logic [31:0] exp);
    logic [31:0] v;
    bus_read(a, v);
    check_equal(test, what, exp, v);
endtask

task automatic pulse_decr(input int s, input int count);
    for (int i = 0; i < count; i++) begin
        @(negedge clk);
        ndtr_decr[s] = 1'b1;
        @(negedge clk);
        ndtr_decr[s] = 1'b0;
    end
endtask

task automatic wait_lisr_bit(input string test, input int bit_idx, input int max_polls);
    logic [31:0] v;
    int          polls;
    polls = 0;
    bus_read(LISR_ADDR, v);
    while (!v[bit_idx] && polls < max_polls) begin
        polls++;
        bus_read(LISR_ADDR, v);
    end
    if (!v[bit_idx]) begin
        timeout_errors++;
        $display("%s: LISR bit %0d was never set, gave up after %0d reads",
                 test, bit_idx, polls + 1);
    end
endtask

task automatic reset_and_readback();
    string       t = "reset_and_readback";
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] cr_exp;
    logic [3:0]  strb;
    check_read(t, "LISR", LISR_ADDR, 32'h0);
    check_read(t, "LIFCR", LIFCR_ADDR, 32'h0);
    for (int s = 0; s < N; s++) begin
        for (int r = R_CR; r <= R_MAR; r++) begin
            check_read(t, "reset value", reg_addr(s, r), 32'h0);
        end
    end
    for (int s = 0; s < N; s++) begin
        for (int r = R_PAR; r <= R_MAR; r++) begin
            v1   = $urandom();
            v2   = $urandom();
            strb = 4'($urandom());
            bus_write(reg_addr(s, r), 4'hf, v1);
            check_read(t, "full write", reg_addr(s, r), v1);
            bus_write(reg_addr(s, r), strb, v2);
            check_read(t, "strobed write", reg_addr(s, r), apply_strobes(v1, v2, strb));
            check_equal(t, "address output", apply_strobes(v1, v2, strb),
                        (r == R_PAR) ? par[s] : mar[s]);
        end
        v1 = $urandom();
        v2 = $urandom();
        bus_write(reg_addr(s, R_NDTR), 4'hf, v1);
        check_read(t, "NDTR full", reg_addr(s, R_NDTR), {16'h0, v1[15:0]});
        bus_write(reg_addr(s, R_NDTR), 4'b0010, v2);
        check_read(t, "NDTR high byte", reg_addr(s, R_NDTR), {16'h0, v2[15:8], v1[7:0]});
        v1 = $urandom() & ~32'h1;  // keep the stream disabled
        v2 = $urandom() & ~32'h1;
        bus_write(reg_addr(s, R_CR), 4'hf, v1);
        check_read(t, "CR full", reg_addr(s, R_CR), v1 & CR_MASK);
        check_equal(t, "cfg full", {19'h0, cfg_from_word(v1)}, {19'h0, cfg[s]});
        cr_exp = apply_strobes(v1, v2, 4'b0010);
        bus_write(reg_addr(s, R_CR), 4'b0010, v2);
        check_read(t, "CR byte 1", reg_addr(s, R_CR), cr_exp & CR_MASK);
        check_equal(t, "cfg byte 1", {19'h0, cfg_from_word(cr_exp)}, {19'h0, cfg[s]});
        bus_write(reg_addr(s, R_CR), 4'hf, 32'h0);
    end
endtask

task automatic write_protect();
    string t = "write_protect";
    bus_write(reg_addr(0, R_PAR), 4'hf, 32'h4000_1000);
    bus_write(reg_addr(0, R_MAR), 4'hf, 32'h2000_0000);
    bus_write(reg_addr(0, R_NDTR), 4'hf, 32'd10);
    bus_write(reg_addr(0, R_CR), 4'h1, 32'h0000_0041);  // mem_to_periph, enabled
    check_equal(t, "en", 32'd1, {31'h0, cfg[0].en});
    bus_write(reg_addr(0, R_PAR), 4'hf, 32'hdead_beef);
    bus_write(reg_addr(0, R_MAR), 4'hf, 32'hcafe_f00d);
    bus_write(reg_addr(0, R_NDTR), 4'hf, 32'd99);
    bus_write(reg_addr(0, R_CR), 4'h3, 32'h0000_0791);  // new DIR and byte 1 dropped, TCIE kept
    check_read(t, "PAR", reg_addr(0, R_PAR), 32'h4000_1000);
    check_read(t, "MAR", reg_addr(0, R_MAR), 32'h2000_0000);
    check_read(t, "NDTR", reg_addr(0, R_NDTR), 32'd10);
    check_read(t, "CR", reg_addr(0, R_CR), 32'h0000_0051);
    if (N > 1) begin
        bus_write(reg_addr(1, R_PAR), 4'hf, 32'h1234_5678);
        check_read(t, "other stream PAR", reg_addr(1, R_PAR), 32'h1234_5678);
    end
    bus_write(reg_addr(0, R_CR), 4'h1, 32'h0);
    check_read(t, "CR after disable", reg_addr(0, R_CR), 32'h0000_0040);
    bus_write(reg_addr(0, R_CR), 4'hf, 32'h0);
endtask

task automatic normal_transfer();
    string       t = "normal_transfer";
    int          n = 8;
    logic [31:0] v;
    bus_write(LIFCR_ADDR, 4'hf, 32'hffff_ffff);
    bus_write(reg_addr(0, R_NDTR), 4'hf, 32'(n));
    bus_write(reg_addr(0, R_CR), 4'h3, 32'h0000_0601);  // minc, pinc, enabled
    pulse_decr(0, n / 2);
    wait_lisr_bit(t, `DMA_ISR_HT_BIT, 10);
    check_equal(t, "o_htif", 32'd1, {31'h0, htif[0]});
    bus_read(LISR_ADDR, v);
    check_equal(t, "tc before the end", 32'd0, {31'h0, v[`DMA_ISR_TC_BIT]});
    pulse_decr(0, n - n / 2);
    wait_lisr_bit(t, `DMA_ISR_TC_BIT, 10);
    bus_read(reg_addr(0, R_CR), v);
    check_equal(t, "en after completion", 32'd0, {31'h0, v[`DMA_CR_EN_BIT]});
    check_equal(t, "o_ndtr", 32'd0, {16'h0, ndtr[0]});
    check_equal(t, "o_tcif", 32'd1, {31'h0, tcif[0]});
endtask

task automatic circular_reload();
    string       t = "circular_reload";
    int          s = N - 1;
    int          n = 6;
    logic [31:0] v;
    bus_write(LIFCR_ADDR, 4'hf, 32'hffff_ffff);
    bus_write(reg_addr(s, R_NDTR), 4'hf, 32'(n));
    bus_write(reg_addr(s, R_CR), 4'h3, 32'h0000_0101);  // circular, enabled
    pulse_decr(s, n);
    wait_lisr_bit(t, 8 * s + `DMA_ISR_TC_BIT, 10);
    check_read(t, "NDTR reloaded", reg_addr(s, R_NDTR), 32'(n));
    bus_read(reg_addr(s, R_CR), v);
    check_equal(t, "en kept", 32'd1, {31'h0, v[`DMA_CR_EN_BIT]});
    check_equal(t, "o_ndtr", 32'(n), {16'h0, ndtr[s]});
    bus_write(reg_addr(s, R_CR), 4'h3, 32'h0);
    bus_write(reg_addr(s, R_CR), 4'h3, 32'h0);  // byte 1 only clears once disabled
endtask

task automatic error_and_clear();
    string       t = "error_and_clear";
    int          s1 = N - 1;
    logic [31:0] exp;
    exp = 32'h0;
    bus_write(LIFCR_ADDR, 4'hf, 32'hffff_ffff);
    check_read(t, "LISR cleared", LISR_ADDR, 32'h0);
    @(negedge clk);
    teif_set = '1;
    @(negedge clk);
    teif_set = '0;
    for (int s = 0; s < N; s++) begin
        exp = exp | (32'h1 << (8 * s + `DMA_ISR_TE_BIT));
    end
    wait_lisr_bit(t, 8 * s1 + `DMA_ISR_TE_BIT, 10);
    check_read(t, "LISR te set", LISR_ADDR, exp);
    for (int s = 0; s < N; s++) begin
        check_equal(t, "o_teif set", 32'd1, {31'h0, teif[s]});
    end
    // right bit, but this stream's byte strobe is low
    bus_write(LIFCR_ADDR, 4'hf & ~(4'b1 << s1), 32'h1 << (8 * s1 + `DMA_ISR_TE_BIT));
    check_read(t, "strobe low", LISR_ADDR, exp);
    bus_write(LIFCR_ADDR, 4'hf, (32'h1 << (8 * s1 + `DMA_ISR_TC_BIT)) |
                                (32'h1 << (8 * s1 + `DMA_ISR_HT_BIT)));
    check_read(t, "other bits", LISR_ADDR, exp);
    if (N > 1) begin
        bus_write(LIFCR_ADDR, 4'hf, 32'h1 << `DMA_ISR_TE_BIT);
        exp = exp & ~(32'h1 << `DMA_ISR_TE_BIT);
        check_read(t, "stream 0 te only", LISR_ADDR, exp);
    end
    bus_write(LIFCR_ADDR, 4'b1 << s1, 32'h1 << (8 * s1 + `DMA_ISR_TE_BIT));
    exp = exp & ~(32'h1 << (8 * s1 + `DMA_ISR_TE_BIT));
    check_read(t, "te cleared", LISR_ADDR, exp);
    check_equal(t, "o_teif cleared", 32'd0, 32'(teif));
endtask

initial begin
    void'($urandom(32'h58f7eaf7));
    check_errors   = 0;
    timeout_errors = 0;
    nreset    = 1'b0;
    addr      = 32'h0;
    read_en   = 1'b0;
    write_en  = 1'b0;
    strobe    = 4'h0;
    wdata     = 32'h0;
    ndtr_decr = '0;
    teif_set  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    nreset = 1'b1;
    reset_and_readback();
    write_protect();
    normal_transfer();
    circular_reload();
    error_and_clear();
    $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/dma_pkg.sv
design/dma_bus_decode.sv
design/dma_stream_regs.sv
design/dma_irq_flags.sv
design/dma_regs.sv
tests/dma_regs_assert.sv
tests/dma_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dma_regs_tb -f compile.f -Mdir obj_dir \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vdma_regs_tb > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
